/* Makefile */
SIM       = verilator
SIM_FLAGS = --binary --timing --assert -j 0
TOP       = tb_poli_lobinho
FILELIST  = flist.f
RUN_FLAGS = +verilator+error+limit+1000
OBJ_DIR   = obj_dir
SIM_BIN   = $(OBJ_DIR)/V$(TOP)
LOG       = sim.log
SOURCES   = $(shell cat $(FILELIST))

.PHONY: all run clean

all: run

$(SIM_BIN): $(SOURCES) $(FILELIST)
	$(SIM) $(SIM_FLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) $(RUN_FLAGS) > $(LOG) 2>&1; status=$$?; cat $(LOG); \
	if [ $$status -ne 0 ] || grep -q "Simulation failed" $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

/* flist.f */
rtl/lobinho_pkg.sv
rtl/game_control.sv
rtl/role_deal.sv
rtl/target_decoder.sv
rtl/night_resolver.sv
rtl/poli_lobinho.sv
tb/poli_lobinho_checker.sv
tb/tb_poli_lobinho.sv

/* rtl/game_control.sv */
module game_control (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 play,
    input  logic                 pass,
    output lobinho_pkg::player_t current_player,
    output logic                 clear_game,
    output logic                 deal_step,
    output logic                 store_deal,
    output logic                 turn_active,
    output logic                 clear_target,
    output logic                 evaluate,
    output logic                 announce
);

    import lobinho_pkg::*;

    game_state_t state;                               // Current FSM state
    game_state_t state_next;
    logic        pass_sync;                           // First detector stage
    logic        pass_prev;                           // Second detector stage
    logic        pass_pulse;                          // One cycle per press
    logic        last_player;                         // Player 4 holds the turn

    // ------------------------------------------------------------------------
    // Pass edge detector
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            pass_sync <= 1'b0;
            pass_prev <= 1'b0;
        end else begin
            pass_sync <= pass;
            pass_prev <= pass_sync;
        end
    end

    assign pass_pulse = pass_sync & ~pass_prev;       // Rising edge only

    // ------------------------------------------------------------------------
    // Night round FSM
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            state <= IDLE;
        end else begin
            state <= state_next;
        end
    end

    assign last_player = (current_player == player_t'(NUM_PLAYERS - 1));

    always_comb begin
        state_next = state;                           // Hold by default
        case (state)
            IDLE:          if (play) state_next = RESET_ALL;
            RESET_ALL:     state_next = DEAL;
            DEAL:          if (pass_pulse) state_next = STORE_DEAL;   // Freeze the deal
            STORE_DEAL:    state_next = PREPARE_NIGHT;
            PREPARE_NIGHT: state_next = WAIT_TURN;
            WAIT_TURN:     if (pass_pulse) state_next = TURN;
            TURN: begin
                if (pass_pulse) begin
                    state_next = last_player ? END_NIGHT : NEXT_PLAYER;
                end
            end
            NEXT_PLAYER:   state_next = WAIT_TURN;
            END_NIGHT:     state_next = EVALUATE;
            EVALUATE:      state_next = ANNOUNCE;
            ANNOUNCE:      state_next = ANNOUNCE;     // Only reset leaves
            default:       state_next = IDLE;
        endcase
    end

    // Player turn counter
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            current_player <= '0;
        end else if (clear_game || state == PREPARE_NIGHT) begin
            current_player <= '0;
        end else if (state == NEXT_PLAYER) begin
            current_player <= current_player + 3'd1;
        end
    end

    // Moore strobes
    assign clear_game   = (state == IDLE) || (state == RESET_ALL);
    assign deal_step    = (state == DEAL);
    assign store_deal   = (state == STORE_DEAL);
    assign turn_active  = (state == TURN);
    assign clear_target = clear_game || (state == NEXT_PLAYER);    // Fresh pick each turn
    assign evaluate     = (state == EVALUATE);
    assign announce     = (state == ANNOUNCE);

endmodule

/* rtl/lobinho_pkg.sv */
package lobinho_pkg;

    // ------------------------------------------------------------------------
    // Game dimensions and types
    // ------------------------------------------------------------------------
    localparam int NUM_PLAYERS = 5;                   // Seats at the table
    localparam int NUM_DEALS   = 20;                  // 5 wolves x 4 doctors

    typedef logic [2:0] player_t;                     // Player index 0 to 4
    typedef logic [1:0] role_t;                       // Role code
    typedef logic [4:0] deal_t;                       // Deal counter value
    typedef logic [9:0] game_t;                       // Five roles, player 0 on top
    typedef logic [4:0] deaths_t;                     // Bit p set when p is dead
    typedef logic [4:0] buttons_t;                    // One-hot target buttons

    localparam role_t ROLE_VILLAGER = 2'd0;
    localparam role_t ROLE_WOLF     = 2'd1;
    localparam role_t ROLE_DOCTOR   = 2'd2;
    localparam role_t ROLE_NONE     = 2'd3;           // Nothing shown

    typedef enum logic [3:0] {
        IDLE,                                         // Waiting for play
        RESET_ALL,                                    // Clears the game data
        DEAL,                                         // Deal counter spins
        STORE_DEAL,                                   // Latch the dealt game
        PREPARE_NIGHT,                                // Zero the player counter
        WAIT_TURN,                                    // Role hidden between turns
        TURN,                                         // Role shown, target picked
        NEXT_PLAYER,
        END_NIGHT,
        EVALUATE,                                     // Resolve attack vs protect
        ANNOUNCE                                      // Held until reset
    } game_state_t;

    // ------------------------------------------------------------------------
    // Role table
    // ------------------------------------------------------------------------
    // Index bits [4:2] pick the wolf, bits [1:0] rank the doctor among the rest
    function automatic game_t deal_game(deal_t index);
        game_t   game;
        player_t wolf;
        player_t rank;
        player_t doctor;
        game   = '0;                                  // Everyone a villager
        wolf   = index[4:2];
        rank   = {1'b0, index[1:0]};
        doctor = (rank < wolf) ? rank : rank + 3'd1;  // Skip over the wolf
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            if (player_t'(p) == wolf) begin
                game[2*(NUM_PLAYERS-1-p) +: 2] = ROLE_WOLF;
            end else if (player_t'(p) == doctor) begin
                game[2*(NUM_PLAYERS-1-p) +: 2] = ROLE_DOCTOR;
            end
        end
        return game;
    endfunction

endpackage

/* rtl/night_resolver.sv */
module night_resolver (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 clear_game,
    input  logic                 evaluate,
    input  lobinho_pkg::role_t   current_role,
    input  lobinho_pkg::player_t chosen_player,
    output lobinho_pkg::deaths_t deaths
);

    import lobinho_pkg::*;

    player_t attacked_player;                         // Wolf's latest pick
    player_t protected_player;                        // Doctor's latest pick

    // ------------------------------------------------------------------------
    // Night actions
    // ------------------------------------------------------------------------
    // current_role is ROLE_NONE outside a turn so no state test is needed
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            attacked_player  <= '0;
            protected_player <= '0;
        end else if (clear_game) begin
            attacked_player  <= '0;
            protected_player <= '0;
        end else begin
            case (current_role)
                ROLE_WOLF:   attacked_player  <= chosen_player;
                ROLE_DOCTOR: protected_player <= chosen_player;
                default:     ;                        // Villager or hidden
            endcase
        end
    end

    // ------------------------------------------------------------------------
    // Resolution
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            deaths <= '0;
        end else if (clear_game) begin
            deaths <= '0;
        end else if (evaluate && attacked_player != protected_player) begin
            deaths[attacked_player] <= 1'b1;          // Unsaved victim
        end
    end

endmodule

/* rtl/poli_lobinho.sv */
module poli_lobinho (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  play,
    input  logic                  pass,
    input  lobinho_pkg::buttons_t target_buttons,
    output lobinho_pkg::deal_t    seed_index,
    output lobinho_pkg::player_t  current_player,
    output lobinho_pkg::role_t    current_role,
    output lobinho_pkg::deaths_t  deaths,
    output logic                  announce
);

    import lobinho_pkg::*;

    logic    clear_game;                              // IDLE and RESET_ALL
    logic    deal_step;                               // Deal counter enable
    logic    store_deal;                              // Latch dealt game
    logic    turn_active;                             // Role on display
    logic    clear_target;
    logic    evaluate;
    player_t chosen_player;                           // Decoded target

    game_control u_game_control (
        .clock          (clock),
        .reset          (reset),
        .play           (play),
        .pass           (pass),
        .current_player (current_player),
        .clear_game     (clear_game),
        .deal_step      (deal_step),
        .store_deal     (store_deal),
        .turn_active    (turn_active),
        .clear_target   (clear_target),
        .evaluate       (evaluate),
        .announce       (announce)
    );

    role_deal u_role_deal (
        .clock          (clock),
        .reset          (reset),
        .clear_game     (clear_game),
        .deal_step      (deal_step),
        .store_deal     (store_deal),
        .turn_active    (turn_active),
        .current_player (current_player),
        .seed_index     (seed_index),
        .current_role   (current_role)
    );

    target_decoder u_target_decoder (
        .clock          (clock),
        .reset          (reset),
        .clear_target   (clear_target),
        .target_buttons (target_buttons),
        .chosen_player  (chosen_player)
    );

    night_resolver u_night_resolver (
        .clock          (clock),
        .reset          (reset),
        .clear_game     (clear_game),
        .evaluate       (evaluate),
        .current_role   (current_role),
        .chosen_player  (chosen_player),
        .deaths         (deaths)
    );

endmodule

/* rtl/role_deal.sv */
module role_deal (
    input  logic                 clock,
    input  logic                 reset,
    input  logic                 clear_game,
    input  logic                 deal_step,
    input  logic                 store_deal,
    input  logic                 turn_active,
    input  lobinho_pkg::player_t current_player,
    output lobinho_pkg::deal_t   seed_index,
    output lobinho_pkg::role_t   current_role
);

    import lobinho_pkg::*;

    game_t game;                                      // Roles of the dealt game
    role_t player_role;                               // Role of current_player

    // ------------------------------------------------------------------------
    // Deal counter, modulo NUM_DEALS
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            seed_index <= '0;
        end else if (clear_game) begin
            seed_index <= '0;
        end else if (deal_step) begin
            if (seed_index == deal_t'(NUM_DEALS - 1)) begin
                seed_index <= '0;                     // Wrap after the last deal
            end else begin
                seed_index <= seed_index + 5'd1;
            end
        end
    end

    // ------------------------------------------------------------------------
    // Dealt game register
    // ------------------------------------------------------------------------
    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            game <= '0;
        end else if (clear_game) begin
            game <= '0;
        end else if (store_deal) begin
            game <= deal_game(seed_index);            // Counter already frozen here
        end
    end

    // Pick the pair that belongs to the current player
    always_comb begin
        player_role = ROLE_NONE;                      // Out of range index
        for (int p = 0; p < NUM_PLAYERS; p++) begin
            if (current_player == player_t'(p)) begin
                player_role = game[2*(NUM_PLAYERS-1-p) +: 2];
            end
        end
    end

    assign current_role = turn_active ? player_role : ROLE_NONE;   // Hidden off turn

endmodule

/* rtl/target_decoder.sv */
module target_decoder (
    input  logic                  clock,
    input  logic                  reset,
    input  logic                  clear_target,
    input  lobinho_pkg::buttons_t target_buttons,
    output lobinho_pkg::player_t  chosen_player
);

    import lobinho_pkg::*;

    logic any_button;                                 // Some button held

    assign any_button = |target_buttons;

    always_ff @(posedge clock or posedge reset) begin
        if (reset) begin
            chosen_player <= '0;
        end else if (clear_target) begin
            chosen_player <= '0;                      // Between turns
        end else if (any_button) begin
            case (target_buttons)
                5'b00001: chosen_player <= player_t'(0);
                5'b00010: chosen_player <= player_t'(1);
                5'b00100: chosen_player <= player_t'(2);
                5'b01000: chosen_player <= player_t'(3);
                5'b10000: chosen_player <= player_t'(4);
                default:  chosen_player <= player_t'(0);    // Several buttons
            endcase
        end
    end

endmodule

/* tb/poli_lobinho_checker.sv */
module poli_lobinho_checker (
    input logic                 clock,
    input logic                 reset,
    input lobinho_pkg::deal_t   seed_index,
    input lobinho_pkg::role_t   current_role,
    input lobinho_pkg::deaths_t deaths,
    input logic                 announce
);

    import lobinho_pkg::*;

    int failure_count = 0;                            // Read back by the testbench

    // No role on display once the night is over
    role_hidden: assert property (@(posedge clock) disable iff (reset)
        announce |-> current_role == ROLE_NONE)
    else begin
        $error("current_role shown while announce is high");
        failure_count++;
    end

    seed_range: assert property (@(posedge clock) disable iff (reset)
        seed_index < deal_t'(NUM_DEALS))
    else begin
        $error("seed_index out of range");
        failure_count++;
    end

    // Result frozen until the next reset
    deaths_frozen: assert property (@(posedge clock) disable iff (reset)
        announce && $past(announce) |-> $stable(deaths))
    else begin
        $error("deaths changed during announce");
        failure_count++;
    end

endmodule

bind poli_lobinho poli_lobinho_checker u_checker (.*);

/* tb/tb_poli_lobinho.sv */
module tb_poli_lobinho;

    import lobinho_pkg::*;

    localparam int NUM_GAMES      = 20;
    localparam int TIMEOUT_CYCLES = NUM_GAMES * 300;  // About twice a slow game

    logic     clock;
    logic     reset;
    logic     play;
    logic     pass;
    buttons_t target_buttons;
    deal_t    seed_index;
    player_t  current_player;
    role_t    current_role;
    deaths_t  deaths;
    logic     announce;

    int    cycle_count = 0;
    int    error_count = 0;
    int    games_passed = 0;
    int    games_failed = 0;
    string test_name = "setup";

    poli_lobinho DUT (
        .clock          (clock),
        .reset          (reset),
        .play           (play),
        .pass           (pass),
        .target_buttons (target_buttons),
        .seed_index     (seed_index),
        .current_player (current_player),
        .current_role   (current_role),
        .deaths         (deaths),
        .announce       (announce)
    );

    // ------------------------------------------------------------------------
    // Clock and run limit
    // ------------------------------------------------------------------------
    initial clock = 1'b0;
    always #2 clock = ~clock;                         // Period 4

    always @(posedge clock) begin
        cycle_count++;
        if (cycle_count >= TIMEOUT_CYCLES) begin
            $display("Timeout: run still busy after %0d cycles", TIMEOUT_CYCLES);
            $display("Simulation failed");
            $finish;
        end
    end

    task automatic next_cycle();
        @(posedge clock);
        #1;                                           // Off the edge
    endtask

    task automatic wait_cycles(int count);
        repeat (count) next_cycle();
    endtask

    task automatic check_value(string what, int expected, int actual);
        assert (expected == actual) else begin
            $display("Error: %s %s expected %0d actual %0d", test_name, what, expected, actual);
            error_count++;
        end
    endtask

    task automatic check_reset_state(string when);
        check_value({when, " announce"}, 0, int'(announce));
        check_value({when, " deaths"}, 0, int'(deaths));
        check_value({when, " role"}, int'(ROLE_NONE), int'(current_role));
        check_value({when, " player"}, 0, int'(current_player));
        check_value({when, " seed"}, 0, int'(seed_index));
    endtask

    task automatic apply_reset();
        reset          = 1'b1;
        play           = 1'b0;
        pass           = 1'b0;
        target_buttons = '0;
        wait_cycles(5);
        check_reset_state("in reset");
        reset = 1'b0;
        next_cycle();
        check_reset_state("after reset");             // Back in IDLE
    endtask

    // Button presses hold 3 cycles, then release 3
    task automatic press_pass();
        pass = 1'b1;
        wait_cycles(3);
        pass = 1'b0;
        wait_cycles(3);
    endtask

    task automatic press_buttons(buttons_t pattern);
        target_buttons = pattern;
        wait_cycles(3);
        target_buttons = '0;
        wait_cycles(3);
    endtask

    // ------------------------------------------------------------------------
    // Reference model
    // ------------------------------------------------------------------------
    function automatic role_t expected_role(int index, int player);
        int wolf;
        int doctor;
        wolf   = index / 4;                           // Four deals per wolf seat
        doctor = index % 4;
        if (doctor >= wolf) doctor = doctor + 1;      // Skip the wolf's seat
        if (player == wolf) return ROLE_WOLF;
        if (player == doctor) return ROLE_DOCTOR;
        return ROLE_VILLAGER;
    endfunction

    function automatic int decode_target(buttons_t pattern, int previous);
        if (pattern == '0) begin
            return previous;                          // Nothing pressed keeps the pick
        end
        for (int i = 0; i < NUM_PLAYERS; i++) begin
            if (pattern == (buttons_t'(1) << i)) return i;
        end
        return 0;                                     // Several buttons
    endfunction

    function automatic buttons_t random_pattern();
        int       kind;
        buttons_t pattern;
        kind = int'($urandom_range(9, 0));
        if (kind < 6) begin
            pattern = buttons_t'(1) << $urandom_range(4, 0);
        end else if (kind < 8) begin
            pattern = '0;
        end else begin
            pattern = buttons_t'($urandom_range(31, 0));
            while ($countones(pattern) < 2) pattern = buttons_t'($urandom_range(31, 0));
        end
        return pattern;
    endfunction

    // ------------------------------------------------------------------------
    // Games
    // ------------------------------------------------------------------------
    initial begin
        int       held_seed;
        int       abort_turn;
        int       attacked;
        int       saved;
        int       chosen;
        int       game_errors;
        int       deal_wait;
        int       prev_seed;
        bit       moving;
        bit       aborted;
        role_t    role;
        buttons_t first;
        buttons_t pattern;
        string    note;

        reset          = 1'b1;
        play           = 1'b0;
        pass           = 1'b0;
        target_buttons = '0;
        void'($urandom(69064));

        for (int game = 0; game < NUM_GAMES; game++) begin
            test_name   = $sformatf("game%0d", game);
            game_errors = error_count;
            aborted     = 1'b0;
            abort_turn  = (game % 5 == 2) ? int'($urandom_range(4, 0)) : NUM_PLAYERS;
            attacked    = 0;
            saved       = 0;
            apply_reset();
            play = 1'b1;                              // IDLE to RESET_ALL
            next_cycle();
            play = 1'b0;
            deal_wait = int'($urandom_range(40, 0));
            prev_seed = int'(seed_index);
            moving    = 1'b0;
            for (int c = 0; c < deal_wait; c++) begin     // Let the deal spin
                next_cycle();
                if (moving || int'(seed_index) != prev_seed) begin
                    check_value("deal step", (prev_seed + 1) % NUM_DEALS, int'(seed_index));
                    moving = 1'b1;
                end
                prev_seed = int'(seed_index);
            end
            if (deal_wait > 4) check_value("deal running", 1, int'(moving));
            press_pass();
            held_seed = int'(seed_index);
            for (int turn = 0; turn < NUM_PLAYERS; turn++) begin
                check_value("announce before turn", 0, int'(announce));
                press_pass();                         // Opens the turn
                while (current_role == ROLE_NONE) next_cycle();
                if (turn == abort_turn) begin
                    apply_reset();                    // Restart in mid-night
                    aborted = 1'b1;
                    break;
                end
                role = expected_role(held_seed, turn);
                check_value("player", turn, int'(current_player));
                check_value("seed hold", held_seed, int'(seed_index));
                check_value("role", int'(role), int'(current_role));
                check_value("target cleared", 0, int'(DUT.u_target_decoder.chosen_player));
                first   = buttons_t'(1) << $urandom_range(4, 1);  // Nonzero pick first
                pattern = random_pattern();
                chosen  = decode_target(pattern, decode_target(first, 0));
                press_buttons(first);
                press_buttons(pattern);               // Keeps or overrides the first pick
                check_value("target", chosen, int'(DUT.u_target_decoder.chosen_player));
                if (role == ROLE_WOLF) attacked = chosen;
                if (role == ROLE_DOCTOR) saved = chosen;
                check_value("announce in turn", 0, int'(announce));
                press_pass();                         // Closes the turn
            end
            if (!aborted) begin
                while (!announce) next_cycle();
                check_value("role at announce", int'(ROLE_NONE), int'(current_role));
                check_value("deaths", (attacked != saved) ? (1 << attacked) : 0, int'(deaths));
            end
            note = aborted ? $sformatf("reset at turn %0d", abort_turn)
                           : $sformatf("deaths %b", deaths);
            if (error_count == game_errors) begin
                games_passed++;
                $display("%s: ok, seed %0d, %s", test_name, held_seed, note);
            end else begin
                games_failed++;
                $display("%s: FAILED, seed %0d, %s", test_name, held_seed, note);
            end
        end

        test_name = "checker";
        check_value("bound assertion failures", 0, DUT.u_checker.failure_count);
        $display("%0d games: %0d passed, %0d failed, %0d errors",
                 NUM_GAMES, games_passed, games_failed, error_count);
        if (error_count == 0) begin
            $display("Simulation passed");
        end else begin
            $display("Simulation failed");
        end
        $finish;
    end

endmodule
